// File: hdl/tgt_xlate_pkg.sv
//--------------------
// Widths, localparams and PCIe format/type encodings
// Flow class and link-layer command encodings
// Input record and translated header records
//--------------------

`default_nettype none

package tgt_xlate_pkg;

  //--------------------
  // Widths
  //--------------------
  typedef logic [31:0]  dw_t;
  typedef logic [127:0] tlp_hdr_t;     // Dword 0 in bits 127:96
  typedef logic [31:0]  data_t;
  typedef logic         data_par_t;
  typedef logic [9:0]   len_t;         // Length in dwords
  typedef logic [9:0]   tag_t;
  typedef logic [15:0]  rid_t;
  typedef logic [3:0]   be_t;
  typedef logic [63:0]  addr_t;
  typedef logic [7:0]   crd_t;

  localparam int         ADDR_MSB       = 47;     // Higher address bits read as zero
  localparam int         DW_PER_CRD     = 4;
  localparam logic [7:0] MSG_INVAL_CODE = 8'h01;  // Invalidate request message code
  localparam len_t       MSG_INVAL_LEN  = 10'd2;

  //--------------------
  // Encodings
  //--------------------
  typedef enum logic [1:0] {
    FC_P  = 2'd0,
    FC_NP = 2'd1,
    FC_C  = 2'd2
  } fc_e;

  // Format in the top 3 bits, type in the low 5
  typedef enum logic [7:0] {
    MRD3   = 8'h00,
    MRD4   = 8'h20,
    MWR3   = 8'h40,
    MWR4   = 8'h60,
    CFGRD0 = 8'h04,
    CFGWR0 = 8'h44,
    CPL    = 8'h0a,
    CPLD   = 8'h4a,
    CPLLK  = 8'h0b,
    CPLDLK = 8'h4b,
    MSGD2  = 8'h72   // Message with data, ID routed
  } tlp_type_e;

  typedef enum logic [1:0] {
    P_WR     = 2'd0,
    P_MSG_D  = 2'd1,
    P_USR_D  = 2'd2,   // Unsupported, with data
    P_USR_ND = 2'd3    // Unsupported, no data
  } p_cmd_e;

  typedef enum logic [2:0] {
    NP_MEM_RD = 3'd0,
    NP_CFG_WR = 3'd1,
    NP_CFG_RD = 3'd2,
    NP_USR_D  = 3'd3,
    NP_USR_ND = 3'd4
  } np_cmd_e;

  typedef enum logic [2:0] {
    CPL_SC       = 3'd0,
    CPL_UR       = 3'd1,
    CPL_CRS      = 3'd2,
    CPL_CA       = 3'd4,
    CPL_LK_UNSUP = 3'd7
  } cpl_stat_t;

  //--------------------
  // Records
  //--------------------
  typedef struct packed {
    logic      push_cmd;
    fc_e       cmd_fc;
    logic      push_data;
    fc_e       data_fc;
    logic      cpar_err;
    logic      tecrc_err;
    tlp_hdr_t  hdr;
    data_t     data;
    data_par_t data_par;
  } tgt_cmd_t;

  typedef struct packed {
    addr_t      addr;
    tag_t       tag;
    rid_t       reqid;
    be_t        startbe;
    be_t        endbe;
    len_t       length;
    logic       poison;
    logic [2:0] tc;
    logic [2:0] attr;     // {ido, ro, ns}
    logic [2:0] fmt;
    logic [4:0] ttype;
  } req_fields_t;

  typedef struct packed {
    req_fields_t req;
    p_cmd_e      cmd;
    logic        cmdlen_par;
    logic [1:0]  addr_par;   // {ADDR_MSB:32, 31:0}
  } phdr_t;

  typedef struct packed {
    req_fields_t req;
    np_cmd_e     cmd;
    logic        cmdlen_par;
    logic [1:0]  addr_par;
  } nphdr_t;

  typedef struct packed {
    logic [2:0]  tc;
    logic        ido;
    logic        ro;
    logic        ns;
    logic        poison;
    rid_t        rid;       // Requester ID
    rid_t        cid;       // Completer ID
    logic [1:0]  lowaddr;
    logic [11:0] bc;
    cpl_stat_t   status;
    len_t        length;
    logic        wdata;
    tag_t        tag;
  } cplhdr_t;

  typedef struct packed {
    logic cmd_up;
    logic cmd_np;
    logic data_up;
    logic data_np;
    crd_t data_crd;
  } crd_dec_t;

endpackage

`default_nettype wire

// File: hdl/tgt_err_guard.sv
//--------------------
// Header parity and end-to-end CRC error reporting
// Sticky stop bit and header accept strobe
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tgt_err_guard (
  input  logic prim_nonflr_clk,
  input  logic prim_gated_rst_b,
  input  logic push_cmd,
  input  logic cpar_err_in,
  input  logic tecrc_err_in,
  input  logic parchk_en,
  output logic cpar_err,
  output logic tecrc_err,
  output logic hdr_accept
);

  logic stop_q;   // Set by a reported parity error, held until reset

  // Errors count only on a header push, and never once stopped
  assign cpar_err  = push_cmd & cpar_err_in & parchk_en & ~stop_q;
  assign tecrc_err = push_cmd & tecrc_err_in & ~stop_q;   // No enable for CRC

  // A parity error drops its own header
  assign hdr_accept = push_cmd & ~cpar_err & ~stop_q;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      stop_q <= 1'b0;
    end else if (cpar_err) begin
      stop_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/tlp_cmd_decode.sv
//--------------------
// Format/type decode and flow class routing
// Posted and non-posted link-layer command select
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tlp_cmd_decode
  import tgt_xlate_pkg::*;
(
  input  tlp_hdr_t hdr,
  input  fc_e      cmd_fc,
  input  logic     hdr_accept,
  input  logic     push_data,
  input  fc_e      data_fc,
  input  logic     fuse_proc_disable,
  output logic     p_val,
  output logic     np_val,
  output logic     cpl_val,
  output logic     p_push,
  output logic     np_push,
  output logic     cpl_push,
  output p_cmd_e   p_cmd,
  output np_cmd_e  np_cmd,
  output logic     has_data,
  output logic     is_4dw
);

  dw_t       dw0;
  dw_t       dw1;
  tlp_type_e tlp_type;
  logic      msg_inval;   // The one supported MsgD

  assign dw0      = hdr[127:96];
  assign dw1      = hdr[95:64];
  assign tlp_type = tlp_type_e'(dw0[31:24]);
  assign has_data = dw0[30];   // Format bit 1
  assign is_4dw   = dw0[29];   // Format bit 0

  //--------------------
  // Strobes
  //--------------------
  assign p_val   = hdr_accept & (cmd_fc == FC_P);
  assign np_val  = hdr_accept & (cmd_fc == FC_NP);
  assign cpl_val = hdr_accept & (cmd_fc == FC_C);

  // Data beats flow regardless of header state
  assign p_push   = push_data & (data_fc == FC_P);
  assign np_push  = push_data & (data_fc == FC_NP);
  assign cpl_push = push_data & (data_fc == FC_C);

  //--------------------
  // Command select
  //--------------------
  assign msg_inval = (tlp_type == MSGD2) & (dw0[9:0] == MSG_INVAL_LEN) &
                     (dw1[7:0] == MSG_INVAL_CODE);

  always_comb begin
    if (fuse_proc_disable && (msg_inval || (tlp_type == MWR3) || (tlp_type == MWR4))) begin
      p_cmd = P_USR_D;
    end else if (msg_inval) begin
      p_cmd = P_MSG_D;
    end else if ((tlp_type == MWR3) || (tlp_type == MWR4)) begin
      p_cmd = P_WR;
    end else if (has_data) begin
      p_cmd = P_USR_D;
    end else begin
      p_cmd = P_USR_ND;
    end
  end

  always_comb begin
    case (tlp_type)
      MRD3, MRD4: np_cmd = fuse_proc_disable ? NP_USR_ND : NP_MEM_RD;
      CFGWR0:     np_cmd = fuse_proc_disable ? NP_USR_D : NP_CFG_WR;
      CFGRD0:     np_cmd = fuse_proc_disable ? NP_USR_ND : NP_CFG_RD;
      default:    np_cmd = has_data ? NP_USR_D : NP_USR_ND;   // Everything else is UR
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/req_hdr_xlate.sv
//--------------------
// Posted and non-posted request header build
// Address layout, 10-bit tag and header parity
//--------------------

`timescale 1ns/1ps
`default_nettype none

module req_hdr_xlate
  import tgt_xlate_pkg::*;
(
  input  tlp_hdr_t hdr,
  input  logic     is_4dw,
  input  logic     tenbit_tag_en,
  input  p_cmd_e   p_cmd,
  input  np_cmd_e  np_cmd,
  output phdr_t    phdr,
  output nphdr_t   nphdr
);

  dw_t         dw0;
  dw_t         dw1;
  dw_t         dw2;
  dw_t         dw3;
  tlp_type_e   tlp_type;
  req_fields_t fields;
  logic        fld_par;    // Parity over fmt, type and length
  logic [1:0]  addr_par;

  assign {dw0, dw1, dw2, dw3} = hdr;
  assign tlp_type = tlp_type_e'(dw0[31:24]);

  //--------------------
  // Shared fields
  //--------------------
  always_comb begin
    if ((tlp_type == CFGRD0) || (tlp_type == CFGWR0)) begin
      // Bus/dev/func, 4 zero bits, register number, dword aligned
      fields.addr = {32'd0, dw2[31:16], 4'd0, dw2[11:2], 2'd0};
    end else if (is_4dw) begin
      fields.addr = {dw2, dw3[31:2], 2'd0};
      fields.addr[63:ADDR_MSB+1] = '0;   // Not implemented
    end else begin
      fields.addr = {32'd0, dw2[31:2], 2'd0};
    end

    // Tag bits 9 and 8 sit in reserved header bits
    fields.tag     = {tenbit_tag_en & dw0[23], tenbit_tag_en & dw0[19], dw1[15:8]};
    fields.reqid   = dw1[31:16];
    fields.endbe   = dw1[7:4];
    fields.startbe = dw1[3:0];
    fields.length  = dw0[9:0];
    fields.poison  = dw0[14];
    fields.tc      = dw0[22:20];
    fields.attr    = {dw0[18], dw0[13:12]};
    fields.fmt     = dw0[31:29];
    fields.ttype   = dw0[28:24];
  end

  assign fld_par  = ^{fields.fmt, fields.ttype, fields.length};
  assign addr_par = {^fields.addr[ADDR_MSB:32], ^fields.addr[31:0]};

  //--------------------
  // Header assembly
  //--------------------
  always_comb begin
    phdr.req        = fields;
    phdr.cmd        = p_cmd;
    phdr.cmdlen_par = fld_par ^ (^p_cmd);
    phdr.addr_par   = addr_par;
  end

  always_comb begin
    nphdr.req        = fields;
    nphdr.cmd        = np_cmd;
    nphdr.cmdlen_par = fld_par ^ (^np_cmd);
    nphdr.addr_par   = addr_par;
  end

endmodule

`default_nettype wire

// File: hdl/cpl_hdr_xlate.sv
//--------------------
// Completion header build
// Status remap and 10-bit tag recovery
//--------------------

`timescale 1ns/1ps
`default_nettype none

module cpl_hdr_xlate
  import tgt_xlate_pkg::*;
(
  input  tlp_hdr_t hdr,
  input  logic     tenbit_tag_en,
  output cplhdr_t  cplhdr
);

  dw_t        dw0;
  dw_t        dw1;
  dw_t        dw2;
  tlp_type_e  tlp_type;
  logic [2:0] raw_stat;

  assign {dw0, dw1, dw2} = hdr[127:32];   // Dword 3 unused for completions
  assign tlp_type = tlp_type_e'(dw0[31:24]);
  assign raw_stat = dw1[15:13];

  always_comb begin
    cplhdr.tc      = dw0[22:20];
    cplhdr.ido     = dw0[18];
    cplhdr.ro      = dw0[13];
    cplhdr.ns      = dw0[12];
    cplhdr.poison  = dw0[14];
    cplhdr.rid     = dw2[31:16];
    cplhdr.cid     = dw1[31:16];
    cplhdr.lowaddr = dw2[1:0];
    cplhdr.bc      = dw1[11:0];
    cplhdr.length  = dw0[9:0];
    cplhdr.wdata   = dw0[30];
    cplhdr.tag     = {tenbit_tag_en & dw0[23], tenbit_tag_en & dw0[19], dw2[15:8]};

    // Locked completions first, then reserved encodings to UR
    if ((tlp_type == CPLLK) || (tlp_type == CPLDLK)) begin
      cplhdr.status = CPL_LK_UNSUP;
    end else if ((raw_stat == 3'd3) || (raw_stat >= 3'd5)) begin
      cplhdr.status = CPL_UR;
    end else begin
      cplhdr.status = cpl_stat_t'(raw_stat);
    end
  end

endmodule

`default_nettype wire

// File: hdl/tgt_credit_dec.sv
//--------------------
// Header and data credit decrement
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tgt_credit_dec
  import tgt_xlate_pkg::*;
(
  input  logic     p_val,
  input  logic     np_val,
  input  logic     has_data,
  input  len_t     length,
  output crd_dec_t crd_dec
);

  logic        cmd_up;
  logic        data_up;
  logic [10:0] len_rnd;   // One bit wider so rounding cannot wrap

  assign cmd_up  = p_val | np_val;
  assign data_up = has_data & cmd_up;

  // Round up to whole data credits
  assign len_rnd = {1'b0, length} + 11'(DW_PER_CRD - 1);

  always_comb begin
    crd_dec.cmd_up   = cmd_up;
    crd_dec.cmd_np   = np_val;
    crd_dec.data_up  = data_up;
    crd_dec.data_np  = has_data & np_val;
    crd_dec.data_crd = data_up ? crd_t'(len_rnd / DW_PER_CRD) : '0;
  end

endmodule

`default_nettype wire

// File: hdl/tgt_xlate_top.sv
//--------------------
// Target translator top level
// Decode, header build, credit and error guard
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tgt_xlate_top
  import tgt_xlate_pkg::*;
(
  input  logic      prim_nonflr_clk,
  input  logic      prim_gated_rst_b,
  input  tgt_cmd_t  tgt_cmd,
  input  logic      tenbit_tag_en,
  input  logic      parchk_en,
  input  logic      fuse_proc_disable,
  output logic      lli_phdr_val,
  output phdr_t     lli_phdr,
  output logic      lli_nphdr_val,
  output nphdr_t    lli_nphdr,
  output logic      lli_cplhdr_val,
  output cplhdr_t   lli_cplhdr,
  output logic      lli_pdata_push,
  output logic      lli_npdata_push,
  output logic      lli_cpldata_push,
  output data_t     lli_pkt_data,
  output data_par_t lli_pkt_data_par,
  output crd_dec_t  crd_dec,
  output logic      cpar_err,
  output logic      tecrc_err
);

  logic    hdr_accept;
  p_cmd_e  p_cmd;
  np_cmd_e np_cmd;
  logic    has_data;
  logic    is_4dw;

  tgt_err_guard u_guard (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .push_cmd         (tgt_cmd.push_cmd),
    .cpar_err_in      (tgt_cmd.cpar_err),
    .tecrc_err_in     (tgt_cmd.tecrc_err),
    .parchk_en        (parchk_en),
    .cpar_err         (cpar_err),
    .tecrc_err        (tecrc_err),
    .hdr_accept       (hdr_accept)
  );

  tlp_cmd_decode u_decode (
    .hdr               (tgt_cmd.hdr),
    .cmd_fc            (tgt_cmd.cmd_fc),
    .hdr_accept        (hdr_accept),
    .push_data         (tgt_cmd.push_data),
    .data_fc           (tgt_cmd.data_fc),
    .fuse_proc_disable (fuse_proc_disable),
    .p_val             (lli_phdr_val),
    .np_val            (lli_nphdr_val),
    .cpl_val           (lli_cplhdr_val),
    .p_push            (lli_pdata_push),
    .np_push           (lli_npdata_push),
    .cpl_push          (lli_cpldata_push),
    .p_cmd             (p_cmd),
    .np_cmd            (np_cmd),
    .has_data          (has_data),
    .is_4dw            (is_4dw)
  );

  tgt_credit_dec u_credit (
    .p_val    (lli_phdr_val),
    .np_val   (lli_nphdr_val),
    .has_data (has_data),
    .length   (lli_phdr.req.length),   // Same field in both request headers
    .crd_dec  (crd_dec)
  );

  req_hdr_xlate u_req (
    .hdr           (tgt_cmd.hdr),
    .is_4dw        (is_4dw),
    .tenbit_tag_en (tenbit_tag_en),
    .p_cmd         (p_cmd),
    .np_cmd        (np_cmd),
    .phdr          (lli_phdr),
    .nphdr         (lli_nphdr)
  );

  cpl_hdr_xlate u_cpl (
    .hdr           (tgt_cmd.hdr),
    .tenbit_tag_en (tenbit_tag_en),
    .cplhdr        (lli_cplhdr)
  );

  // Payload zeroed between beats, parity passed as is
  assign lli_pkt_data     = tgt_cmd.push_data ? tgt_cmd.data : '0;
  assign lli_pkt_data_par = tgt_cmd.data_par;

endmodule

`default_nettype wire

// File: dv/tgt_xlate_chk.sv
//--------------------
// Bound assertions on the translator top level
// One header valid per cycle, stop after parity error, credit zero rule
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tgt_xlate_chk
  import tgt_xlate_pkg::*;
(
  input logic     prim_nonflr_clk,
  input logic     prim_gated_rst_b,
  input logic     lli_phdr_val,
  input logic     lli_nphdr_val,
  input logic     lli_cplhdr_val,
  input logic     cpar_err,
  input crd_dec_t crd_dec
);

  int unsigned fail_cnt = 0;   // Failed assertions so far
  logic        perr_seen_q;    // Parity error reported since reset
  logic        any_val;

  assign any_val = lli_phdr_val | lli_nphdr_val | lli_cplhdr_val;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      perr_seen_q <= 1'b0;
    end else if (cpar_err) begin
      perr_seen_q <= 1'b1;
    end
  end

  a_one_valid: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
      $onehot0({lli_phdr_val, lli_nphdr_val, lli_cplhdr_val}))
    else begin
      fail_cnt++;
      $error("More than one header valid in the same cycle");
    end

  // The erroring header itself is dropped too
  a_stop_blocks: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
      (perr_seen_q || cpar_err) |-> !any_val)
    else begin
      fail_cnt++;
      $error("Header valid after a parity error");
    end

  a_crd_zero: assert property (@(posedge prim_nonflr_clk) disable iff (!prim_gated_rst_b)
      !crd_dec.data_up |-> (crd_dec.data_crd == '0))
    else begin
      fail_cnt++;
      $error("Data credits without a data decrement");
    end

endmodule

bind tgt_xlate_top tgt_xlate_chk u_chk (
  .prim_nonflr_clk  (prim_nonflr_clk),
  .prim_gated_rst_b (prim_gated_rst_b),
  .lli_phdr_val     (lli_phdr_val),
  .lli_nphdr_val    (lli_nphdr_val),
  .lli_cplhdr_val   (lli_cplhdr_val),
  .cpar_err         (cpar_err),
  .crd_dec          (crd_dec)
);

`default_nettype wire

// File: dv/tgt_xlate_tb.sv
//--------------------
// Testbench for the target translator
// Clock, reset, LFSR stimulus, reference model, compare tasks, watchdog
//--------------------

`timescale 1ns/1ps
`default_nettype none

module tgt_xlate_tb
  import tgt_xlate_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;
  localparam int N_MAIN     = 3000;   // No live parity errors
  localparam int N_STOP     = 200;    // After the forced parity error
  localparam int N_POST     = 800;    // After the second reset
  localparam int N_TOTAL    = N_MAIN + 1 + N_STOP + N_POST + 2 * (RST_CYCLES + 1);
  localparam int MARGIN     = 100;

  logic      prim_nonflr_clk;
  logic      prim_gated_rst_b;
  tgt_cmd_t  cmd_in;
  logic      tenbit_tag_en;
  logic      parchk_en;
  logic      fuse_proc_disable;
  logic      lli_phdr_val;
  phdr_t     lli_phdr;
  logic      lli_nphdr_val;
  nphdr_t    lli_nphdr;
  logic      lli_cplhdr_val;
  cplhdr_t   lli_cplhdr;
  logic      lli_pdata_push;
  logic      lli_npdata_push;
  logic      lli_cpldata_push;
  data_t     lli_pkt_data;
  data_par_t lli_pkt_data_par;
  crd_dec_t  crd_dec;
  logic      cpar_err;
  logic      tecrc_err;

  logic [31:0] lfsr;
  logic        m_stop;   // Model of the sticky stop bit

  tgt_xlate_top dut0 (
    .prim_nonflr_clk   (prim_nonflr_clk),
    .prim_gated_rst_b  (prim_gated_rst_b),
    .tgt_cmd           (cmd_in),
    .tenbit_tag_en     (tenbit_tag_en),
    .parchk_en         (parchk_en),
    .fuse_proc_disable (fuse_proc_disable),
    .lli_phdr_val      (lli_phdr_val),
    .lli_phdr          (lli_phdr),
    .lli_nphdr_val     (lli_nphdr_val),
    .lli_nphdr         (lli_nphdr),
    .lli_cplhdr_val    (lli_cplhdr_val),
    .lli_cplhdr        (lli_cplhdr),
    .lli_pdata_push    (lli_pdata_push),
    .lli_npdata_push   (lli_npdata_push),
    .lli_cpldata_push  (lli_cpldata_push),
    .lli_pkt_data      (lli_pkt_data),
    .lli_pkt_data_par  (lli_pkt_data_par),
    .crd_dec           (crd_dec),
    .cpar_err          (cpar_err),
    .tecrc_err         (tecrc_err)
  );

  initial begin
    prim_nonflr_clk = 1'b0;
    forever #(CLK_PERIOD / 2) prim_nonflr_clk = ~prim_nonflr_clk;
  end

  //--------------------
  // Failure and compare
  //--------------------
  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic phdr_equal(input string name, input phdr_t act, input phdr_t exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic nphdr_equal(input string name, input nphdr_t act, input nphdr_t exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic cplhdr_equal(input string name, input cplhdr_t act, input cplhdr_t exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic crd_equal(input string name, input crd_dec_t act, input crd_dec_t exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic data_equal(input string name, input data_t act, input data_t exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic bit_equal(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
      abort_run();
    end
  endtask

  //--------------------
  // Random source
  //--------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic take_bits(input int n, output logic [127:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[126:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] type_by_index(input logic [3:0] idx);
    case (idx)
      4'd0:    return MRD3;
      4'd1:    return MRD4;
      4'd2:    return MWR3;
      4'd3:    return MWR4;
      4'd4:    return CFGRD0;
      4'd5:    return CFGWR0;
      4'd6:    return CPL;
      4'd7:    return CPLD;
      4'd8:    return CPLLK;
      4'd9:    return CPLDLK;
      default: return MSGD2;
    endcase
  endfunction

  //--------------------
  // Reference model
  //--------------------
  function automatic req_fields_t req_fields_of(input tlp_hdr_t h, input logic ten);
    dw_t         dw0;
    dw_t         dw1;
    dw_t         dw2;
    dw_t         dw3;
    logic [63:0] keep;
    req_fields_t f;
    {dw0, dw1, dw2, dw3} = h;
    keep = ((64'd1 << (ADDR_MSB + 1)) - 64'd1) & ~64'd3;
    if ((dw0[31:24] == CFGRD0) || (dw0[31:24] == CFGWR0)) begin
      f.addr = 64'({dw2[31:16], 4'd0, dw2[11:2]}) << 2;   // Bus/dev/func and register
    end else if (dw0[29]) begin
      f.addr = {dw2, dw3} & keep;
    end else begin
      f.addr = {32'd0, dw2} & ~64'd3;
    end
    f.tag     = {ten & dw0[23], ten & dw0[19], dw1[15:8]};
    f.reqid   = dw1[31:16];
    f.startbe = dw1[3:0];
    f.endbe   = dw1[7:4];
    f.length  = dw0[9:0];
    f.poison  = dw0[14];
    f.tc      = dw0[22:20];
    f.attr    = {dw0[18], dw0[13], dw0[12]};
    f.fmt     = dw0[31:29];
    f.ttype   = dw0[28:24];
    return f;
  endfunction

  function automatic p_cmd_e posted_cmd_of(input tlp_hdr_t h, input logic fuse);
    dw_t  dw0;
    logic is_wr;
    logic is_msg;
    dw0    = h[127:96];
    is_wr  = (dw0[31:24] == MWR3) || (dw0[31:24] == MWR4);
    is_msg = (dw0[31:24] == MSGD2) && (dw0[9:0] == 10'd2) && (h[71:64] == 8'h01);
    if (fuse && (is_wr || is_msg)) begin
      return P_USR_D;
    end else if (is_msg) begin
      return P_MSG_D;
    end else if (is_wr) begin
      return P_WR;
    end
    return dw0[30] ? P_USR_D : P_USR_ND;
  endfunction

  function automatic np_cmd_e nonposted_cmd_of(input tlp_hdr_t h, input logic fuse);
    logic [7:0] t;
    t = h[127:120];
    if ((t == MRD3) || (t == MRD4)) begin
      return fuse ? NP_USR_ND : NP_MEM_RD;
    end else if (t == CFGWR0) begin
      return fuse ? NP_USR_D : NP_CFG_WR;
    end else if (t == CFGRD0) begin
      return fuse ? NP_USR_ND : NP_CFG_RD;
    end
    return h[126] ? NP_USR_D : NP_USR_ND;
  endfunction

  function automatic cplhdr_t cpl_header_of(input tlp_hdr_t h, input logic ten);
    dw_t        dw0;
    dw_t        dw1;
    dw_t        dw2;
    logic [2:0] raw;
    cplhdr_t    c;
    {dw0, dw1, dw2} = h[127:32];
    raw       = dw1[15:13];
    c.tc      = dw0[22:20];
    c.ido     = dw0[18];
    c.ro      = dw0[13];
    c.ns      = dw0[12];
    c.poison  = dw0[14];
    c.rid     = dw2[31:16];
    c.cid     = dw1[31:16];
    c.lowaddr = dw2[1:0];
    c.bc      = dw1[11:0];
    c.length  = dw0[9:0];
    c.wdata   = dw0[30];
    c.tag     = {ten & dw0[23], ten & dw0[19], dw2[15:8]};
    if ((dw0[31:24] == CPLLK) || (dw0[31:24] == CPLDLK)) begin
      c.status = CPL_LK_UNSUP;
    end else if ((raw == 3'd3) || (raw >= 3'd5)) begin
      c.status = CPL_UR;   // Reserved status codes
    end else begin
      c.status = cpl_stat_t'(raw);
    end
    return c;
  endfunction

  task automatic compare_all();
    logic        e_cpar;
    logic        accept;
    logic        has_d;
    req_fields_t f;
    phdr_t       e_ph;
    nphdr_t      e_nph;
    crd_dec_t    e_crd;
    has_d  = cmd_in.hdr[126];
    e_cpar = cmd_in.push_cmd & cmd_in.cpar_err & parchk_en & ~m_stop;
    accept = cmd_in.push_cmd & ~e_cpar & ~m_stop;
    f      = req_fields_of(cmd_in.hdr, tenbit_tag_en);

    e_ph.req         = f;
    e_ph.cmd         = posted_cmd_of(cmd_in.hdr, fuse_proc_disable);
    e_ph.cmdlen_par  = ^{f.fmt, f.ttype, f.length, e_ph.cmd};
    e_ph.addr_par    = {^f.addr[ADDR_MSB:32], ^f.addr[31:0]};
    e_nph.req        = f;
    e_nph.cmd        = nonposted_cmd_of(cmd_in.hdr, fuse_proc_disable);
    e_nph.cmdlen_par = ^{f.fmt, f.ttype, f.length, e_nph.cmd};
    e_nph.addr_par   = e_ph.addr_par;

    e_crd.cmd_np   = accept & (cmd_in.cmd_fc == FC_NP);
    e_crd.cmd_up   = (accept & (cmd_in.cmd_fc == FC_P)) | e_crd.cmd_np;
    e_crd.data_up  = has_d & e_crd.cmd_up;
    e_crd.data_np  = has_d & e_crd.cmd_np;
    e_crd.data_crd = e_crd.data_up ?
                     crd_t'((int'(f.length) + DW_PER_CRD - 1) / DW_PER_CRD) : '0;

    bit_equal("lli_phdr_val", lli_phdr_val, accept & (cmd_in.cmd_fc == FC_P));
    bit_equal("lli_nphdr_val", lli_nphdr_val, e_crd.cmd_np);
    bit_equal("lli_cplhdr_val", lli_cplhdr_val, accept & (cmd_in.cmd_fc == FC_C));
    phdr_equal("lli_phdr", lli_phdr, e_ph);
    nphdr_equal("lli_nphdr", lli_nphdr, e_nph);
    cplhdr_equal("lli_cplhdr", lli_cplhdr, cpl_header_of(cmd_in.hdr, tenbit_tag_en));
    crd_equal("crd_dec", crd_dec, e_crd);
    bit_equal("lli_pdata_push", lli_pdata_push, cmd_in.push_data & (cmd_in.data_fc == FC_P));
    bit_equal("lli_npdata_push", lli_npdata_push,
              cmd_in.push_data & (cmd_in.data_fc == FC_NP));
    bit_equal("lli_cpldata_push", lli_cpldata_push,
              cmd_in.push_data & (cmd_in.data_fc == FC_C));
    data_equal("lli_pkt_data", lli_pkt_data, cmd_in.push_data ? cmd_in.data : '0);
    bit_equal("lli_pkt_data_par", lli_pkt_data_par, cmd_in.data_par);
    bit_equal("cpar_err", cpar_err, e_cpar);
    bit_equal("tecrc_err", tecrc_err, cmd_in.push_cmd & cmd_in.tecrc_err & ~m_stop);
    if (dut0.u_chk.fail_cnt != 0) begin
      $display("A bound assertion failed at %0t", $time);
      abort_run();
    end
    if (e_cpar) m_stop = 1'b1;   // Takes effect at the coming rising edge
  endtask

  //--------------------
  // Stimulus
  //--------------------
  task automatic drive_random(input bit allow_perr);
    logic [127:0] r;
    logic [127:0] h;
    take_bits(3, r);
    cmd_in.push_cmd = (r[2:0] != 3'd0);
    take_bits(2, r);
    cmd_in.cmd_fc = fc_e'(r[1:0]);   // 3 selects no class
    take_bits(128, h);
    take_bits(4, r);
    if (r[3:0] < 4'd11) h[127:120] = type_by_index(r[3:0]);   // Else a random encoding
    take_bits(1, r);
    if (r[0] && (h[127:120] == MSGD2)) begin
      h[105:96] = 10'd2;   // Valid invalidate request
      h[71:64]  = 8'h01;
    end
    cmd_in.hdr = h;
    take_bits(5, r);
    cmd_in.cpar_err = (r[4:0] == 5'd0);
    take_bits(4, r);
    cmd_in.tecrc_err = (r[3:0] == 4'd0);
    take_bits(2, r);
    parchk_en = (r[1:0] != 2'd0) & (allow_perr | ~cmd_in.cpar_err);
    take_bits(1, r);
    cmd_in.push_data = r[0];
    take_bits(2, r);
    cmd_in.data_fc = fc_e'(r[1:0]);
    take_bits(32, r);
    cmd_in.data = r[31:0];
    take_bits(1, r);
    cmd_in.data_par = r[0];
    take_bits(1, r);
    tenbit_tag_en = r[0];
    take_bits(2, r);
    fuse_proc_disable = (r[1:0] == 2'd0);
  endtask

  // Mode 0 keeps parity errors out, 1 allows them, 2 forces one
  task automatic run_cycle(input int mode);
    @(negedge prim_nonflr_clk);
    drive_random(mode != 0);
    if (mode == 2) begin
      cmd_in.push_cmd = 1'b1;
      cmd_in.cpar_err = 1'b1;
      parchk_en       = 1'b1;
    end
    #(CLK_PERIOD / 4);
    compare_all();
  endtask

  task automatic apply_reset();
    @(negedge prim_nonflr_clk);
    cmd_in.push_cmd  = 1'b0;
    prim_gated_rst_b = 1'b0;
    repeat (RST_CYCLES) @(negedge prim_nonflr_clk);
    prim_gated_rst_b = 1'b1;
    m_stop           = 1'b0;
  endtask

  initial begin
    prim_gated_rst_b  = 1'b0;
    cmd_in            = '0;
    tenbit_tag_en     = 1'b0;
    parchk_en         = 1'b0;
    fuse_proc_disable = 1'b0;
    lfsr              = 32'hcc69_0a30;
    m_stop            = 1'b0;
    apply_reset();
    repeat (N_MAIN) run_cycle(0);
    run_cycle(2);
    repeat (N_STOP) run_cycle(1);   // Headers stay blocked
    apply_reset();
    repeat (N_POST) run_cycle(1);
    @(negedge prim_nonflr_clk);     // Last cycle reaches the bound assertions
    if (dut0.u_chk.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      abort_run();
    end
  end

  initial begin
    #((N_TOTAL + MARGIN) * CLK_PERIOD);
    $display("Timeout: the test did not finish in the expected time");
    abort_run();
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/tgt_xlate_pkg.sv
hdl/tgt_err_guard.sv
hdl/tlp_cmd_decode.sv
hdl/req_hdr_xlate.sv
hdl/cpl_hdr_xlate.sv
hdl/tgt_credit_dec.sv
hdl/tgt_xlate_top.sv
dv/tgt_xlate_chk.sv
dv/tgt_xlate_tb.sv
